// File: rtl/datapath_consts.svh
//####################################################################
// constants shared by the execution datapath blocks
// reset vector, status byte bit positions and BCD correction limits
// include in any module that needs one of these values
//####################################################################

`ifndef DATAPATH_CONSTS_SVH
`define DATAPATH_CONSTS_SVH

// program counter value loaded while rstN is low
`define RESET_PC 16'hF000

// bit positions inside the packed status byte, bits 4 and 5 read as zero
`define STATUS_C 3'd0
`define STATUS_Z 3'd1
`define STATUS_I 3'd2
`define STATUS_D 3'd3
`define STATUS_V 3'd6
`define STATUS_N 3'd7

// a BCD digit above this value needs the +6 correction
`define BCD_LOW_LIMIT 4'd9
`define BCD_HIGH_LIMIT 4'd9

`endif

// File: rtl/datapathPkg.sv
//####################################################################
// types shared by the execution datapath and its testbench
// opcodes, ALU operations, instruction and control words,
// the status byte layout and the architectural state bundle
//####################################################################

package datapathPkg;

	// instruction set handled by the datapath
	typedef enum logic [4:0] {
		OP_NOP, OP_LDA, OP_LDX, OP_LDY,
		OP_ADC, OP_SBC, OP_AND, OP_ORA,
		OP_EOR, OP_LSR, OP_TAX, OP_TAY,
		OP_TXA, OP_SEC, OP_CLC, OP_SED,
		OP_CLD, OP_JMP
	} opcodeT;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_PASS, ALU_SUM, ALU_AND, ALU_EOR, ALU_OR, ALU_SHR
	} aluOpT;

	// operand multiplexer selects
	typedef enum logic [1:0] {ASRC_A, ASRC_X, ASRC_ZERO} aSrcT;
	typedef enum logic [1:0] {BSRC_OPER, BSRC_INV, BSRC_ZERO} bSrcT;

	// one instruction from the sequencer, 8-bit ops use the low byte
	typedef struct packed {
		opcodeT opcode;
		logic [15:0] operand;
	} instWordT;

	// decoded strobes for a single cycle
	typedef struct packed {
		aluOpT aluOp;
		aSrcT aSrcSel;
		bSrcT bSrcSel;
		logic useCarryIn;
		logic loadA;
		logic loadX;
		logic loadY;
		logic updNZ;
		logic updC;
		logic updV;
		logic setC;
		logic clrC;
		logic setD;
		logic clrD;
		logic decimalAllowed;
		logic pcJump;
		logic [1:0] pcStep;
	} ctrlWordT;

	// status byte as N V - - D I Z C
	typedef struct packed {
		logic n;
		logic v;
		logic [1:0] zero;
		logic d;
		logic i;
		logic z;
		logic c;
	} flagsT;

	// visible state after each committed instruction
	typedef struct packed {
		logic [7:0] a;
		logic [7:0] x;
		logic [7:0] y;
		flagsT flags;
		logic [15:0] pc;
	} archStateT;

endpackage

// File: rtl/opDecode.sv
//####################################################################
// instruction decoder for the execution datapath
// maps an opcode to the control word of strobes used in one cycle
// purely combinational, outputs an idle word while valid is low
//####################################################################

`timescale 1ns/1ps

module opDecode (
	input  datapathPkg::opcodeT   opcode,
	input  logic                  valid,
	output datapathPkg::ctrlWordT ctrl
);

	always_comb begin
		// idle word: no loads, no flag strobes, PC holds
		ctrl = '0;
		ctrl.aluOp = datapathPkg::ALU_PASS;
		ctrl.aSrcSel = datapathPkg::ASRC_ZERO;
		ctrl.bSrcSel = datapathPkg::BSRC_ZERO;
		if (valid) begin
			// most ops are single byte, immediates override below
			ctrl.pcStep = 2'd1;
			case (opcode)
				datapathPkg::OP_LDA, datapathPkg::OP_LDX, datapathPkg::OP_LDY: begin
					// operand passes through with A side forced to zero
					ctrl.bSrcSel = datapathPkg::BSRC_OPER;
					ctrl.loadA = (opcode == datapathPkg::OP_LDA);
					ctrl.loadX = (opcode == datapathPkg::OP_LDX);
					ctrl.loadY = (opcode == datapathPkg::OP_LDY);
					ctrl.updNZ = 1'b1;
					ctrl.pcStep = 2'd2;
				end
				datapathPkg::OP_ADC, datapathPkg::OP_SBC: begin
					ctrl.aluOp = datapathPkg::ALU_SUM;
					ctrl.aSrcSel = datapathPkg::ASRC_A;
					// subtract is A + ~M + C
					ctrl.bSrcSel = (opcode == datapathPkg::OP_SBC) ?
						datapathPkg::BSRC_INV : datapathPkg::BSRC_OPER;
					ctrl.useCarryIn = 1'b1;
					ctrl.loadA = 1'b1;
					ctrl.updNZ = 1'b1;
					ctrl.updC = 1'b1;
					ctrl.updV = 1'b1;
					// decimal correction is only wired up for add
					ctrl.decimalAllowed = (opcode == datapathPkg::OP_ADC);
					ctrl.pcStep = 2'd2;
				end
				datapathPkg::OP_AND, datapathPkg::OP_ORA, datapathPkg::OP_EOR: begin
					ctrl.aluOp = (opcode == datapathPkg::OP_AND) ? datapathPkg::ALU_AND :
						(opcode == datapathPkg::OP_ORA) ? datapathPkg::ALU_OR :
						datapathPkg::ALU_EOR;
					ctrl.aSrcSel = datapathPkg::ASRC_A;
					ctrl.bSrcSel = datapathPkg::BSRC_OPER;
					ctrl.loadA = 1'b1;
					ctrl.updNZ = 1'b1;
					ctrl.pcStep = 2'd2;
				end
				datapathPkg::OP_LSR: begin
					// bit 0 of A drops into C
					ctrl.aluOp = datapathPkg::ALU_SHR;
					ctrl.aSrcSel = datapathPkg::ASRC_A;
					ctrl.loadA = 1'b1;
					ctrl.updNZ = 1'b1;
					ctrl.updC = 1'b1;
				end
				datapathPkg::OP_TAX, datapathPkg::OP_TAY: begin
					ctrl.aSrcSel = datapathPkg::ASRC_A;
					ctrl.loadX = (opcode == datapathPkg::OP_TAX);
					ctrl.loadY = (opcode == datapathPkg::OP_TAY);
					ctrl.updNZ = 1'b1;
				end
				datapathPkg::OP_TXA: begin
					ctrl.aSrcSel = datapathPkg::ASRC_X;
					ctrl.loadA = 1'b1;
					ctrl.updNZ = 1'b1;
				end
				datapathPkg::OP_SEC: ctrl.setC = 1'b1;
				datapathPkg::OP_CLC: ctrl.clrC = 1'b1;
				datapathPkg::OP_SED: ctrl.setD = 1'b1;
				datapathPkg::OP_CLD: ctrl.clrD = 1'b1;
				datapathPkg::OP_JMP: begin
					ctrl.pcJump = 1'b1;
					ctrl.pcStep = 2'd0;
				end
				// NOP and unused codes just step the PC
				default: ctrl.pcStep = 2'd1;
			endcase
		end
	end

endmodule

// File: rtl/aluCore.sv
//####################################################################
// 8-bit ALU of the execution datapath
// add with carry in two nibble steps, AND, OR, EOR and shift right
// combinational, result and carry are qualified by the decoder strobes
//####################################################################

`timescale 1ns/1ps

module aluCore (
	input  logic [7:0]           opA,
	input  logic [7:0]           opB,
	input  logic                 carryIn,
	input  datapathPkg::aluOpT   aluOp,
	output logic [7:0]           result,
	output logic                 halfCarry,
	output logic                 carryOut,
	output logic                 overflow
);

	// nibble sums, bit 4 is the carry into the next nibble
	logic [4:0] lowSum;
	logic [4:0] highSum;
	logic [7:0] binSum;

	// low nibble first so the half carry is visible to decimal adjust
	assign lowSum = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'b0, carryIn};
	assign highSum = {1'b0, opA[7:4]} + {1'b0, opB[7:4]} + {4'b0, lowSum[4]};
	assign binSum = {highSum[3:0], lowSum[3:0]};

	// exposed for every op, only the sum path consumes it
	assign halfCarry = lowSum[4];

	always_comb begin
		result = binSum;
		carryOut = 1'b0;
		overflow = 1'b0;
		case (aluOp)
			datapathPkg::ALU_SUM: begin
				result = binSum;
				carryOut = highSum[4];
				// same operand signs but the sum sign flipped
				overflow = (opA[7] == opB[7]) && (binSum[7] != opA[7]);
			end
			datapathPkg::ALU_AND: begin
				result = opA & opB;
			end
			datapathPkg::ALU_EOR: begin
				result = opA ^ opB;
			end
			// pass relies on the unused operand being forced to zero
			datapathPkg::ALU_PASS, datapathPkg::ALU_OR: begin
				result = opA | opB;
			end
			datapathPkg::ALU_SHR: begin
				// logical shift, zero into bit 7
				result = {1'b0, opA[7:1]};
				carryOut = opA[0];
			end
			default: begin
				result = binSum;
			end
		endcase
	end

endmodule

// File: rtl/decimalAdjust.sv
//####################################################################
// BCD correction stage after the ALU adder
// adds 6 to each digit that overflowed, active only for decimal ADC
// combinational, passes the binary sum through when disabled
//####################################################################

`timescale 1ns/1ps

`include "datapath_consts.svh"

module decimalAdjust (
	input  logic [7:0] binSum,
	input  logic       halfCarry,
	input  logic       binCarry,
	input  logic       enable,
	output logic [7:0] adjSum,
	output logic       adjCarry
);

	logic fixLow;
	logic fixHigh;
	logic [7:0] correction;

	// low digit past 9 or it already carried into the high digit
	assign fixLow = (binSum[3:0] > `BCD_LOW_LIMIT) || halfCarry;

	// whole byte past 99 or the binary add carried out
	assign fixHigh = (binSum > {`BCD_HIGH_LIMIT, `BCD_LOW_LIMIT}) || binCarry;

	// both corrections land in one add, wraps mod 256
	assign correction = {1'b0, fixHigh, fixHigh, 1'b0, 1'b0, fixLow, fixLow, 1'b0};

	always_comb begin
		if (enable) begin
			adjSum = binSum + correction;
			// a corrected high digit always means a decimal carry
			adjCarry = fixHigh;
		end else begin
			adjSum = binSum;
			adjCarry = binCarry;
		end
	end

endmodule

// File: rtl/statusReg.sv
//####################################################################
// processor status register, N V - - D I Z C
// each flag has its own update or set and clear strobes from decode
// updates on phi2 together with the data registers
//####################################################################

`timescale 1ns/1ps

`include "datapath_consts.svh"

module statusReg (
	input  logic                  phi2,
	input  logic                  rstN,
	input  datapathPkg::ctrlWordT ctrl,
	input  logic [7:0]            result,
	input  logic                  carry,
	input  logic                  overflow,
	output datapathPkg::flagsT    flags
);

	logic [7:0] statusQ;

	always_ff @(posedge phi2) begin
		if (!rstN) begin
			// all flags clear out of reset, including I
			statusQ <= 8'h00;
		end else begin
			// N and Z track the byte written to the destination
			if (ctrl.updNZ) begin
				statusQ[`STATUS_N] <= result[7];
				statusQ[`STATUS_Z] <= (result == 8'h00);
			end
			// explicit set and clear win over the arithmetic carry
			if (ctrl.setC) begin
				statusQ[`STATUS_C] <= 1'b1;
			end else if (ctrl.clrC) begin
				statusQ[`STATUS_C] <= 1'b0;
			end else if (ctrl.updC) begin
				statusQ[`STATUS_C] <= carry;
			end
			if (ctrl.updV) begin
				statusQ[`STATUS_V] <= overflow;
			end
			if (ctrl.setD) begin
				statusQ[`STATUS_D] <= 1'b1;
			end else if (ctrl.clrD) begin
				statusQ[`STATUS_D] <= 1'b0;
			end
			// I has no strobe here and bits 4,5 are never written
		end
	end

	assign flags = datapathPkg::flagsT'(statusQ);

endmodule

// File: rtl/programCounter.sv
//####################################################################
// 16-bit program counter with its incrementer
// steps by 0, 1 or 2 per cycle or loads a jump target
// the low byte carry ripples into the high byte adder
//####################################################################

`timescale 1ns/1ps

`include "datapath_consts.svh"

module programCounter (
	input  logic        phi2,
	input  logic        rstN,
	input  logic [1:0]  pcStep,
	input  logic        pcJump,
	input  logic [15:0] target,
	output logic [15:0] pc
);

	logic [8:0] lowInc;
	logic [7:0] highInc;

	// low byte plus step, bit 8 feeds the high byte
	assign lowInc = {1'b0, pc[7:0]} + {7'b0, pcStep};
	assign highInc = pc[15:8] + {7'b0, lowInc[8]};

	always_ff @(posedge phi2) begin
		if (!rstN) begin
			pc <= `RESET_PC;
		end else if (pcJump) begin
			pc <= target;
		end else begin
			// step of zero holds the PC on idle cycles
			pc <= {highInc, lowInc[7:0]};
		end
	end

endmodule

// File: rtl/execDatapath.sv
//####################################################################
// single-cycle execution datapath, top level
// holds A, X and Y, selects ALU operands and commits results on phi2
// one instruction per cycle, state updates after the sampling edge
//####################################################################

`timescale 1ns/1ps

module execDatapath (
	input  logic                   phi2,
	input  logic                   rstN,
	input  logic                   instValid,
	input  datapathPkg::instWordT  inst,
	output datapathPkg::archStateT state
);

	datapathPkg::ctrlWordT ctrl;
	datapathPkg::flagsT flags;

	logic [7:0] aReg;
	logic [7:0] xReg;
	logic [7:0] yReg;
	logic [15:0] pc;

	logic [7:0] opA;
	logic [7:0] opB;
	logic carryIn;
	logic [7:0] aluResult;
	logic aluHalfCarry;
	logic aluCarry;
	logic aluOverflow;
	logic [7:0] finalResult;
	logic finalCarry;

	opDecode i_opDecode (
		.opcode(inst.opcode),
		.valid(instValid),
		.ctrl(ctrl)
	);

	// A side operand: accumulator, X or zero
	always_comb begin
		case (ctrl.aSrcSel)
			datapathPkg::ASRC_A: opA = aReg;
			datapathPkg::ASRC_X: opA = xReg;
			default: opA = 8'h00;
		endcase
	end

	// B side operand, inverted copy feeds SBC
	always_comb begin
		case (ctrl.bSrcSel)
			datapathPkg::BSRC_OPER: opB = inst.operand[7:0];
			datapathPkg::BSRC_INV: opB = ~inst.operand[7:0];
			default: opB = 8'h00;
		endcase
	end

	assign carryIn = ctrl.useCarryIn & flags.c;

	aluCore i_aluCore (
		.opA(opA),
		.opB(opB),
		.carryIn(carryIn),
		.aluOp(ctrl.aluOp),
		.result(aluResult),
		.halfCarry(aluHalfCarry),
		.carryOut(aluCarry),
		.overflow(aluOverflow)
	);

	// decimal only when D is set and the op is ADC
	decimalAdjust i_decimalAdjust (
		.binSum(aluResult),
		.halfCarry(aluHalfCarry),
		.binCarry(aluCarry),
		.enable(flags.d & ctrl.decimalAllowed),
		.adjSum(finalResult),
		.adjCarry(finalCarry)
	);

	// V stays from the binary sum
	statusReg i_statusReg (
		.phi2(phi2),
		.rstN(rstN),
		.ctrl(ctrl),
		.result(finalResult),
		.carry(finalCarry),
		.overflow(aluOverflow),
		.flags(flags)
	);

	programCounter i_programCounter (
		.phi2(phi2),
		.rstN(rstN),
		.pcStep(ctrl.pcStep),
		.pcJump(ctrl.pcJump),
		.target(inst.operand),
		.pc(pc)
	);

	// register file, load strobes are low on idle cycles
	always_ff @(posedge phi2) begin
		if (!rstN) begin
			aReg <= 8'h00;
			xReg <= 8'h00;
			yReg <= 8'h00;
		end else begin
			if (ctrl.loadA) begin
				aReg <= finalResult;
			end
			if (ctrl.loadX) begin
				xReg <= finalResult;
			end
			if (ctrl.loadY) begin
				yReg <= finalResult;
			end
		end
	end

	always_comb begin
		state.a = aReg;
		state.x = xReg;
		state.y = yReg;
		state.flags = flags;
		state.pc = pc;
	end

endmodule

// File: bench/tbExecDatapath.sv
//####################################################################
// testbench for the single-cycle execution datapath
// directed ADC, SBC, decimal, logic, transfer and PC cases, then a
// seeded random instruction stream checked every cycle by a model
//####################################################################

`timescale 1ns/1ps

`include "datapath_consts.svh"

module tbExecDatapath;

	localparam int RESET_CYCLES = 16;
	localparam int DIRECTED_CYCLES = 200;
	localparam int RAND_CYCLES = 3000;
	// every cycle is 4 ns, plus some slack for the closing checks
	localparam int TIMEOUT_NS = (RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES) * 4 + 400;

	logic phi2;
	logic rstN;
	logic instValid;
	datapathPkg::instWordT inst;
	datapathPkg::archStateT state;

	datapathPkg::archStateT expState;
	logic checking;
	int errorCount;
	int checkCount;

	execDatapath i_execDatapath (
		.phi2(phi2),
		.rstN(rstN),
		.instValid(instValid),
		.inst(inst),
		.state(state)
	);

	always #2 phi2 = ~phi2;

	// next architectural state from the instruction set rules
	function automatic datapathPkg::archStateT refStep(input datapathPkg::archStateT s,
			input logic valid, input datapathPkg::instWordT in);
		datapathPkg::archStateT n;
		logic [7:0] m;
		logic [7:0] res;
		logic [8:0] sum9;
		logic [4:0] low5;
		logic [7:0] corr;
		logic writeNZ;
		n = s;
		m = in.operand[7:0];
		res = 8'h00;
		writeNZ = 1'b0;
		if (!valid) begin
			return s;
		end
		// implied ops step by one, immediates override
		n.pc = s.pc + 16'd1;
		case (in.opcode)
			datapathPkg::OP_LDA: begin
				n.a = m;
				res = m;
				writeNZ = 1'b1;
				n.pc = s.pc + 16'd2;
			end
			datapathPkg::OP_LDX: begin
				n.x = m;
				res = m;
				writeNZ = 1'b1;
				n.pc = s.pc + 16'd2;
			end
			datapathPkg::OP_LDY: begin
				n.y = m;
				res = m;
				writeNZ = 1'b1;
				n.pc = s.pc + 16'd2;
			end
			datapathPkg::OP_ADC, datapathPkg::OP_SBC: begin
				// subtract adds the ones complement plus C
				if (in.opcode == datapathPkg::OP_SBC) begin
					m = ~m;
				end
				sum9 = {1'b0, s.a} + {1'b0, m} + {8'h00, s.flags.c};
				low5 = {1'b0, s.a[3:0]} + {1'b0, m[3:0]} + {4'h0, s.flags.c};
				res = sum9[7:0];
				n.flags.c = sum9[8];
				// V always from the binary sum
				n.flags.v = (s.a[7] == m[7]) && (sum9[7] != s.a[7]);
				if (in.opcode == datapathPkg::OP_ADC && s.flags.d) begin
					corr = 8'h00;
					if (res[3:0] > 4'd9 || low5[4]) begin
						corr = corr + 8'h06;
					end
					if (res > 8'h99 || sum9[8]) begin
						corr = corr + 8'h60;
					end
					n.flags.c = (res > 8'h99 || sum9[8]);
					res = res + corr;
				end
				n.a = res;
				writeNZ = 1'b1;
				n.pc = s.pc + 16'd2;
			end
			datapathPkg::OP_AND, datapathPkg::OP_ORA, datapathPkg::OP_EOR: begin
				if (in.opcode == datapathPkg::OP_AND) begin
					res = s.a & m;
				end else if (in.opcode == datapathPkg::OP_ORA) begin
					res = s.a | m;
				end else begin
					res = s.a ^ m;
				end
				n.a = res;
				writeNZ = 1'b1;
				n.pc = s.pc + 16'd2;
			end
			datapathPkg::OP_LSR: begin
				n.flags.c = s.a[0];
				res = {1'b0, s.a[7:1]};
				n.a = res;
				writeNZ = 1'b1;
			end
			datapathPkg::OP_TAX: begin
				n.x = s.a;
				res = s.a;
				writeNZ = 1'b1;
			end
			datapathPkg::OP_TAY: begin
				n.y = s.a;
				res = s.a;
				writeNZ = 1'b1;
			end
			datapathPkg::OP_TXA: begin
				n.a = s.x;
				res = s.x;
				writeNZ = 1'b1;
			end
			datapathPkg::OP_SEC: n.flags.c = 1'b1;
			datapathPkg::OP_CLC: n.flags.c = 1'b0;
			datapathPkg::OP_SED: n.flags.d = 1'b1;
			datapathPkg::OP_CLD: n.flags.d = 1'b0;
			datapathPkg::OP_JMP: n.pc = in.operand;
			default: n.pc = s.pc + 16'd1;
		endcase
		if (writeNZ) begin
			n.flags.n = res[7];
			n.flags.z = (res == 8'h00);
		end
		return n;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] expV,
			input logic [15:0] actV);
		checkCount++;
		assert (actV === expV) else begin
			errorCount++;
			$display("error: %s expected %h actual %h at %0t", name, expV, actV, $time);
		end
	endtask

	// model comparison, outputs are settled on the falling edge
	always @(negedge phi2) begin
		if (checking) begin
			checkValue("state.a", {8'h00, expState.a}, {8'h00, state.a});
			checkValue("state.x", {8'h00, expState.x}, {8'h00, state.x});
			checkValue("state.y", {8'h00, expState.y}, {8'h00, state.y});
			checkValue("state.flags", {8'h00, expState.flags}, {8'h00, state.flags});
			checkValue("state.pc", expState.pc, state.pc);
		end
		// predict what the coming rising edge commits
		if (!rstN) begin
			expState = '0;
			expState.pc = `RESET_PC;
			checking = 1'b1;
		end else begin
			expState = refStep(expState, instValid, inst);
		end
	end

	task automatic issue(input datapathPkg::opcodeT op, input logic [15:0] operand);
		@(posedge phi2);
		instValid <= 1'b1;
		inst.opcode <= op;
		inst.operand <= operand;
	endtask

	// lets the last issued instruction commit, then waits for stable outputs
	task automatic settle();
		@(posedge phi2);
		instValid <= 1'b0;
		@(negedge phi2);
	endtask

	task automatic idleCycles(input int count);
		repeat (count) begin
			@(posedge phi2);
			instValid <= 1'b0;
			// junk on the idle instruction must be ignored
			inst.opcode <= datapathPkg::opcodeT'($urandom_range(0, 17));
			inst.operand <= 16'($urandom);
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("run timed out after %0d ns without finishing", TIMEOUT_NS);
		$display("errors: %0d checks: %0d", errorCount, checkCount);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(74559));
		phi2 = 1'b0;
		rstN = 1'b0;
		instValid = 1'b0;
		inst = '0;
		checking = 1'b0;
		errorCount = 0;
		checkCount = 0;
		repeat (RESET_CYCLES) @(posedge phi2);
		rstN <= 1'b1;
		@(negedge phi2);
		checkValue("state.a", 16'h0000, {8'h00, state.a});
		checkValue("state.x", 16'h0000, {8'h00, state.x});
		checkValue("state.y", 16'h0000, {8'h00, state.y});
		checkValue("state.flags", 16'h0000, {8'h00, state.flags});
		checkValue("state.pc", `RESET_PC, state.pc);

		// binary add, signed overflow then unsigned carry
		issue(datapathPkg::OP_CLC, 16'h0000);
		issue(datapathPkg::OP_LDA, 16'h0050);
		issue(datapathPkg::OP_ADC, 16'h0050);
		settle();
		checkValue("state.a", 16'h00A0, {8'h00, state.a});
		checkValue("state.flags", 16'h00C0, {8'h00, state.flags});
		issue(datapathPkg::OP_ADC, 16'h0060);
		settle();
		checkValue("state.a", 16'h0000, {8'h00, state.a});
		checkValue("state.flags", 16'h0003, {8'h00, state.flags});
		// subtract with borrow, then overflow crossing 80
		issue(datapathPkg::OP_SEC, 16'h0000);
		issue(datapathPkg::OP_LDA, 16'h0010);
		issue(datapathPkg::OP_SBC, 16'h0020);
		settle();
		checkValue("state.a", 16'h00F0, {8'h00, state.a});
		checkValue("state.flags", 16'h0080, {8'h00, state.flags});
		issue(datapathPkg::OP_SEC, 16'h0000);
		issue(datapathPkg::OP_LDA, 16'h0080);
		issue(datapathPkg::OP_SBC, 16'h0001);
		settle();
		checkValue("state.a", 16'h007F, {8'h00, state.a});
		checkValue("state.flags", 16'h0041, {8'h00, state.flags});

		// decimal add, 58 + 46 = 104, V still from the binary 9E
		issue(datapathPkg::OP_SED, 16'h0000);
		issue(datapathPkg::OP_CLC, 16'h0000);
		issue(datapathPkg::OP_LDA, 16'h0058);
		issue(datapathPkg::OP_ADC, 16'h0046);
		settle();
		checkValue("state.a", 16'h0004, {8'h00, state.a});
		checkValue("state.flags", 16'h0049, {8'h00, state.flags});
		issue(datapathPkg::OP_CLC, 16'h0000);
		issue(datapathPkg::OP_LDA, 16'h0012);
		issue(datapathPkg::OP_ADC, 16'h0034);
		settle();
		checkValue("state.a", 16'h0046, {8'h00, state.a});
		checkValue("state.flags", 16'h0008, {8'h00, state.flags});
		// back to binary
		issue(datapathPkg::OP_CLD, 16'h0000);
		issue(datapathPkg::OP_CLC, 16'h0000);
		issue(datapathPkg::OP_LDA, 16'h0058);
		issue(datapathPkg::OP_ADC, 16'h0046);
		settle();
		checkValue("state.a", 16'h009E, {8'h00, state.a});
		checkValue("state.flags", 16'h00C0, {8'h00, state.flags});

		// logic ops and shift
		issue(datapathPkg::OP_LDA, 16'h00F0);
		issue(datapathPkg::OP_AND, 16'h003C);
		issue(datapathPkg::OP_ORA, 16'h000F);
		settle();
		checkValue("state.a", 16'h003F, {8'h00, state.a});
		issue(datapathPkg::OP_EOR, 16'h003F);
		settle();
		checkValue("state.a", 16'h0000, {8'h00, state.a});
		checkValue("state.flags.z", 16'h0001, {15'h0000, state.flags.z});
		issue(datapathPkg::OP_LDA, 16'h0003);
		issue(datapathPkg::OP_LSR, 16'h0000);
		issue(datapathPkg::OP_LSR, 16'h0000);
		settle();
		checkValue("state.a", 16'h0000, {8'h00, state.a});
		checkValue("state.flags.c", 16'h0001, {15'h0000, state.flags.c});
		checkValue("state.flags.z", 16'h0001, {15'h0000, state.flags.z});

		// loads and transfers
		issue(datapathPkg::OP_LDX, 16'h0080);
		issue(datapathPkg::OP_TXA, 16'h0000);
		issue(datapathPkg::OP_TAY, 16'h0000);
		settle();
		checkValue("state.a", 16'h0080, {8'h00, state.a});
		checkValue("state.y", 16'h0080, {8'h00, state.y});
		checkValue("state.flags.n", 16'h0001, {15'h0000, state.flags.n});
		issue(datapathPkg::OP_LDA, 16'h007F);
		issue(datapathPkg::OP_TAX, 16'h0000);
		settle();
		checkValue("state.x", 16'h007F, {8'h00, state.x});
		checkValue("state.flags.n", 16'h0000, {15'h0000, state.flags.n});

		// PC stepping, jump, hold on idle and carry into the high byte
		// 53 bytes of code above, then NOP and LDA add three more
		issue(datapathPkg::OP_NOP, 16'h0000);
		issue(datapathPkg::OP_LDA, 16'h0001);
		settle();
		checkValue("state.pc", 16'hF038, state.pc);
		issue(datapathPkg::OP_JMP, 16'h1234);
		idleCycles(5);
		@(negedge phi2);
		checkValue("state.pc", 16'h1234, state.pc);
		issue(datapathPkg::OP_JMP, 16'h00FF);
		issue(datapathPkg::OP_NOP, 16'h0000);
		settle();
		checkValue("state.pc", 16'h0100, state.pc);

		// random mix, about one idle cycle in four
		for (int i = 0; i < RAND_CYCLES; i++) begin
			@(posedge phi2);
			instValid <= ($urandom_range(0, 3) != 0);
			inst.opcode <= datapathPkg::opcodeT'($urandom_range(0, 17));
			inst.operand <= 16'($urandom);
		end
		idleCycles(2);
		@(negedge phi2);

		$display("errors: %0d checks: %0d", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: files.f
+incdir+rtl
rtl/datapathPkg.sv
rtl/opDecode.sv
rtl/aluCore.sv
rtl/decimalAdjust.sv
rtl/statusReg.sv
rtl/programCounter.sv
rtl/execDatapath.sv
bench/tbExecDatapath.sv

// File: Makefile
# Verilator build and run of the execution datapath testbench

OBJ_DIR = obj_dir

sim:
	verilator --binary --timing -f files.f --top-module tbExecDatapath \
		-Mdir $(OBJ_DIR) -o simv
	out="$$(./$(OBJ_DIR)/simv)"; echo "$$out"; \
		echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf $(OBJ_DIR)

.PHONY: sim clean
